// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_lc4 \
		--Mdir obj_dir -o sim_lc4
	./obj_dir/sim_lc4 | tee /dev/stderr | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+design
design/lc4_isa_pkg.sv
design/lc4_pipe_pkg.sv
design/lc4_wb_if.sv
design/lc4_frontend.sv
design/lc4_register_read.sv
design/lc4_execute.sv
design/lc4_hazard.sv
design/lc4_writeback.sv
design/lc4_processor.sv
test/tb_commit_checker.sv
test/tb_lc4.sv

// ==== design/lc4_defs.svh ====
`ifndef LC4_DEFS_SVH
`define LC4_DEFS_SVH

// Datapath and address width
`define LC4_WORD_W 16
// Architectural registers R0..R7
`define LC4_NREGS 8
`define LC4_SEL_W 3

// First fetch address out of reset
`define LC4_RESET_PC 16'h8200

`endif

// ==== design/lc4_execute.sv ====
`include "lc4_defs.svh"

module lc4_execute (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  lc4_pipe_pkg::opnd_t    i_opnd,
  output lc4_pipe_pkg::mem_t     o_mem,
  output logic                   o_flush,   // Same cycle as the branch
  output logic [`LC4_WORD_W-1:0] o_target,
  lc4_wb_if.sink                 wb
);
  import lc4_isa_pkg::*;

  ctrl_t c;
  logic mem_fwd;
  logic [`LC4_WORD_W-1:0] a_fwd;
  logic [`LC4_WORD_W-1:0] b_fwd;
  logic [`LC4_WORD_W-1:0] op_a;
  logic [`LC4_WORD_W-1:0] op_b;
  logic [`LC4_WORD_W-1:0] imm;
  logic [`LC4_WORD_W-1:0] result;
  logic [2:0] nzp;       // n, z, p
  logic [2:0] nzp_new;
  logic taken;

  // Sign-extended immediate, width set by instruction class
  function automatic logic [`LC4_WORD_W-1:0] imm_of(input logic [`LC4_WORD_W-1:0] insn);
    case (opcode_e'(insn[15:12]))
      OP_BR, OP_CONST: return {{(`LC4_WORD_W-9){insn[8]}}, insn[8:0]};
      OP_JMP:          return {{(`LC4_WORD_W-11){insn[10]}}, insn[10:0]};
      OP_LDR, OP_STR:  return {{(`LC4_WORD_W-6){insn[5]}}, insn[5:0]};
      default:         return {{(`LC4_WORD_W-5){insn[4]}}, insn[4:0]};
    endcase
  endfunction

  assign c = i_opnd.st.ctrl;
  assign imm = imm_of(i_opnd.st.insn);

  // Loads are never bypassed from memory, the stall covers that case
  assign mem_fwd = o_mem.st.valid && o_mem.st.ctrl.reg_we && !o_mem.st.ctrl.is_load;

  assign a_fwd = (mem_fwd && o_mem.st.ctrl.rd == c.rs) ? o_mem.result :
                 (wb.wb_we && wb.wb_sel == c.rs)      ? wb.wb_data   : i_opnd.a;
  assign b_fwd = (mem_fwd && o_mem.st.ctrl.rd == c.rt) ? o_mem.result :
                 (wb.wb_we && wb.wb_sel == c.rt)      ? wb.wb_data   : i_opnd.b;

  // Branch and jump targets are PC+1 plus offset
  assign op_a = (c.is_branch || c.is_jump) ? i_opnd.st.pc + 1'b1 : a_fwd;
  assign op_b = (c.rt_re && !c.is_store) ? b_fwd : imm;  // STR rt is data, not operand

  always_comb begin
    case (c.alu_op)
      ALU_SUB:  result = op_a - op_b;
      ALU_AND:  result = op_a & op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_XOR:  result = op_a ^ op_b;
      ALU_PASS: result = op_b;
      default:  result = op_a + op_b;
    endcase
  end

  assign nzp_new[2] = result[`LC4_WORD_W-1];
  assign nzp_new[1] = (result == '0);
  assign nzp_new[0] = !result[`LC4_WORD_W-1] && (result != '0);

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      nzp <= 3'b000;
    end else if (i_opnd.st.valid && c.nzp_we) begin
      nzp <= nzp_new;
    end
  end

  // Mask in insn[11:9] against current flags
  assign taken = i_opnd.st.valid &&
                 (c.is_jump || (c.is_branch && |(i_opnd.st.insn[11:9] & nzp)));
  assign o_flush = taken;
  assign o_target = result;

  // Execute-to-memory register
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      o_mem <= '0;
    end else begin
      o_mem.st <= i_opnd.st;
      o_mem.result <= result;
      o_mem.sdata <= b_fwd;
    end
  end

endmodule

// ==== design/lc4_frontend.sv ====
`include "lc4_defs.svh"

module lc4_frontend (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  logic                   i_stall,   // Load-use hold
  input  logic                   i_flush,   // Taken branch or jump in execute
  input  logic [`LC4_WORD_W-1:0] i_target,
  input  logic [`LC4_WORD_W-1:0] i_insn,    // Instruction memory data at o_pc
  output logic [`LC4_WORD_W-1:0] o_pc,
  output lc4_pipe_pkg::stage_t   o_stage
);
  import lc4_isa_pkg::*;

  logic [`LC4_WORD_W-1:0] pc;

  function automatic ctrl_t decode(input logic [`LC4_WORD_W-1:0] insn);
    ctrl_t c;
    c = '0;
    c.rs = insn[8:6];
    c.rt = insn[2:0];
    c.rd = insn[11:9];
    c.alu_op = ALU_ADD;
    case (opcode_e'(insn[15:12]))
      OP_BR: c.is_branch = 1'b1;
      OP_ARITH, OP_LOGIC: begin
        c.rs_re = 1'b1;
        c.rt_re = ~insn[5];          // Bit 5 selects imm5 form
        c.reg_we = 1'b1;
        c.nzp_we = 1'b1;
        casez ({insn[14], insn[5:3]})  // insn[14] splits arith from logic
          4'b0000: c.alu_op = ALU_ADD;
          4'b0010: c.alu_op = ALU_SUB;
          4'b01??: c.alu_op = ALU_ADD; // ADD imm5
          4'b1000: c.alu_op = ALU_AND;
          4'b1010: c.alu_op = ALU_OR;
          4'b1011: c.alu_op = ALU_XOR;
          default: begin               // MUL, DIV, NOT, ANDimm retire as no-ops
            c.reg_we = 1'b0;
            c.nzp_we = 1'b0;
          end
        endcase
      end
      OP_LDR: begin
        c.rs_re = 1'b1;
        c.reg_we = 1'b1;
        c.is_load = 1'b1;              // NZP untouched by loads here
      end
      OP_STR: begin
        c.rs_re = 1'b1;
        c.rt = insn[11:9];             // Store data register
        c.rt_re = 1'b1;
        c.is_store = 1'b1;
      end
      OP_CONST: begin
        c.reg_we = 1'b1;
        c.nzp_we = 1'b1;
        c.alu_op = ALU_PASS;
      end
      OP_JMP: c.is_jump = insn[11];    // JMPR form not supported
      default: ;
    endcase
    return c;
  endfunction

  // PC, flush beats stall
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      pc <= `LC4_RESET_PC;
    end else if (i_flush) begin
      pc <= i_target;
    end else if (!i_stall) begin
      pc <= pc + 1'b1;
    end
  end

  // Decode-to-read register
  always_ff @(posedge gwe) begin
    if (!i_rst_n || i_flush) begin
      o_stage <= '0;
    end else if (!i_stall) begin
      o_stage.valid <= 1'b1;
      o_stage.pc <= pc;
      o_stage.insn <= i_insn;
      o_stage.ctrl <= decode(i_insn);
    end
  end

  assign o_pc = pc;  // Fetch address

endmodule

// ==== design/lc4_hazard.sv ====
module lc4_hazard (
  input  lc4_isa_pkg::ctrl_t i_exec_ctrl,
  input  logic               i_exec_valid,
  input  lc4_isa_pkg::ctrl_t i_read_ctrl,
  input  logic               i_read_valid,
  output logic               o_stall
);

  logic rs_dep;
  logic rt_dep;

  // Register read stage waits on a load result still in execute
  assign rs_dep = i_read_ctrl.rs_re && (i_read_ctrl.rs == i_exec_ctrl.rd);
  assign rt_dep = i_read_ctrl.rt_re && (i_read_ctrl.rt == i_exec_ctrl.rd);

  // One bubble is enough, writeback bypass covers the rest
  assign o_stall = i_exec_valid && i_exec_ctrl.is_load &&
                   i_read_valid && (rs_dep || rt_dep);

endmodule

// ==== design/lc4_isa_pkg.sv ====
`include "lc4_defs.svh"

package lc4_isa_pkg;

  // Instruction classes kept in this subset, insn[15:12]
  typedef enum logic [3:0] {
    OP_BR    = 4'h0,  // BRnzp with 9-bit offset
    OP_ARITH = 4'h1,  // ADD, SUB, ADD imm5
    OP_LOGIC = 4'h5,  // AND, OR, XOR
    OP_LDR   = 4'h6,
    OP_STR   = 4'h7,
    OP_CONST = 4'h9,
    OP_JMP   = 4'hC   // Only the PC-relative form
  } opcode_e;

  // Targets and addresses go through ALU_ADD as well
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS  // Immediate straight through, CONST
  } alu_op_e;

  typedef struct packed {
    logic [`LC4_SEL_W-1:0] rs;
    logic [`LC4_SEL_W-1:0] rt;
    logic [`LC4_SEL_W-1:0] rd;
    logic rs_re;
    logic rt_re;
    logic reg_we;
    logic nzp_we;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jump;
    alu_op_e alu_op;
  } ctrl_t;

endpackage

// ==== design/lc4_pipe_pkg.sv ====
`include "lc4_defs.svh"

package lc4_pipe_pkg;

  // Decode to read
  typedef struct packed {
    logic valid;                    // Low for bubbles and squashed slots
    logic [`LC4_WORD_W-1:0] pc;
    logic [`LC4_WORD_W-1:0] insn;
    lc4_isa_pkg::ctrl_t ctrl;
  } stage_t;

  // Read to execute
  typedef struct packed {
    stage_t st;
    logic [`LC4_WORD_W-1:0] a;      // rs value
    logic [`LC4_WORD_W-1:0] b;      // rt value
  } opnd_t;

  // Execute to memory
  typedef struct packed {
    stage_t st;
    logic [`LC4_WORD_W-1:0] result; // ALU result or memory address
    logic [`LC4_WORD_W-1:0] sdata;  // Store data, already bypassed
  } mem_t;

endpackage

// ==== design/lc4_processor.sv ====
`include "lc4_defs.svh"

module lc4_processor (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  output logic [`LC4_WORD_W-1:0] o_imem_addr,
  input  logic [`LC4_WORD_W-1:0] i_imem_insn,
  output logic [`LC4_WORD_W-1:0] o_dmem_addr,
  output logic                   o_dmem_we,
  output logic [`LC4_WORD_W-1:0] o_dmem_wdata,
  input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
  output logic                   o_commit_valid,    // Retiring instruction
  output logic [`LC4_WORD_W-1:0] o_commit_pc,
  output logic [`LC4_WORD_W-1:0] o_commit_insn,
  output logic                   o_commit_reg_we,
  output logic [`LC4_SEL_W-1:0]  o_commit_reg_sel,
  output logic [`LC4_WORD_W-1:0] o_commit_reg_data
);
  import lc4_pipe_pkg::*;

  stage_t dec_stage;  // Decode to read
  opnd_t  exe_opnd;   // Read to execute
  mem_t   mem_stage;  // Execute to memory
  logic   stall;
  logic   flush;
  logic [`LC4_WORD_W-1:0] target;

  lc4_wb_if wb_bus ();

  lc4_frontend u_frontend (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_stall(stall), .i_flush(flush),
    .i_target(target), .i_insn(i_imem_insn), .o_pc(o_imem_addr), .o_stage(dec_stage)
  );

  lc4_register_read u_register_read (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_stall(stall), .i_flush(flush),
    .i_stage(dec_stage), .o_opnd(exe_opnd), .wb(wb_bus)
  );

  lc4_execute u_execute (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_opnd(exe_opnd), .o_mem(mem_stage),
    .o_flush(flush), .o_target(target), .wb(wb_bus)
  );

  lc4_hazard u_hazard (
    .i_exec_ctrl(exe_opnd.st.ctrl), .i_exec_valid(exe_opnd.st.valid),
    .i_read_ctrl(dec_stage.ctrl), .i_read_valid(dec_stage.valid), .o_stall(stall)
  );

  lc4_writeback u_writeback (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_mem(mem_stage), .i_dmem_rdata(i_dmem_rdata),
    .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
    .wb(wb_bus)
  );

  // Commit trace straight off the writeback register
  assign o_commit_valid = wb_bus.wb_valid;
  assign o_commit_pc = wb_bus.wb_pc;
  assign o_commit_insn = wb_bus.wb_insn;
  assign o_commit_reg_we = wb_bus.wb_we;
  assign o_commit_reg_sel = wb_bus.wb_sel;
  assign o_commit_reg_data = wb_bus.wb_data;

endmodule

// ==== design/lc4_register_read.sv ====
`include "lc4_defs.svh"

module lc4_register_read (
  input  logic                 gwe,
  input  logic                 i_rst_n,
  input  logic                 i_stall,
  input  logic                 i_flush,
  input  lc4_pipe_pkg::stage_t i_stage,
  output lc4_pipe_pkg::opnd_t  o_opnd,
  lc4_wb_if.sink               wb
);

  logic [`LC4_WORD_W-1:0] regs [`LC4_NREGS];
  logic [`LC4_WORD_W-1:0] rs_val;
  logic [`LC4_WORD_W-1:0] rt_val;
  logic rs_hit;
  logic rt_hit;

  // Register file, written by the retiring instruction
  always_ff @(posedge gwe) begin
    if (wb.wb_we) begin
      regs[wb.wb_sel] <= wb.wb_data;
    end
  end

  // Write-before-read: take the value being written this same cycle
  assign rs_hit = wb.wb_we && (wb.wb_sel == i_stage.ctrl.rs);
  assign rt_hit = wb.wb_we && (wb.wb_sel == i_stage.ctrl.rt);

  assign rs_val = rs_hit ? wb.wb_data : regs[i_stage.ctrl.rs];
  assign rt_val = rt_hit ? wb.wb_data : regs[i_stage.ctrl.rt];

  // Read-to-execute register
  // A stall leaves the instruction in read and sends a bubble forward
  always_ff @(posedge gwe) begin
    if (!i_rst_n || i_flush || i_stall) begin
      o_opnd <= '0;
    end else begin
      o_opnd.st <= i_stage;
      o_opnd.a <= rs_val;
      o_opnd.b <= rt_val;
    end
  end

endmodule

// ==== design/lc4_wb_if.sv ====
`include "lc4_defs.svh"

interface lc4_wb_if;
  logic                   wb_valid;  // Instruction retires this cycle
  logic [`LC4_WORD_W-1:0] wb_pc;
  logic [`LC4_WORD_W-1:0] wb_insn;
  logic                   wb_we;     // Qualified by valid
  logic [`LC4_SEL_W-1:0]  wb_sel;
  logic [`LC4_WORD_W-1:0] wb_data;

  modport source (
    output wb_valid, wb_pc, wb_insn, wb_we, wb_sel, wb_data
  );

  modport sink (
    input wb_valid, wb_pc, wb_insn, wb_we, wb_sel, wb_data
  );
endinterface

// ==== design/lc4_writeback.sv ====
`include "lc4_defs.svh"

module lc4_writeback (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  lc4_pipe_pkg::mem_t     i_mem,
  input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,  // Same-cycle read data
  output logic [`LC4_WORD_W-1:0] o_dmem_addr,
  output logic                   o_dmem_we,
  output logic [`LC4_WORD_W-1:0] o_dmem_wdata,
  lc4_wb_if.source               wb
);
  import lc4_pipe_pkg::*;

  stage_t wb_st;
  logic [`LC4_WORD_W-1:0] wb_data_q;
  logic mem_access;

  assign mem_access = i_mem.st.valid && (i_mem.st.ctrl.is_load || i_mem.st.ctrl.is_store);

  assign o_dmem_addr = mem_access ? i_mem.result : '0;  // Zero when no access
  assign o_dmem_we = i_mem.st.valid && i_mem.st.ctrl.is_store;
  assign o_dmem_wdata = i_mem.sdata;

  // Memory-to-writeback register
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      wb_st <= '0;
    end else begin
      wb_st <= i_mem.st;
    end
  end

  always_ff @(posedge gwe) begin
    wb_data_q <= i_mem.st.ctrl.is_load ? i_dmem_rdata : i_mem.result;
  end

  assign wb.wb_valid = wb_st.valid;
  assign wb.wb_pc = wb_st.pc;
  assign wb.wb_insn = wb_st.insn;
  assign wb.wb_we = wb_st.valid && wb_st.ctrl.reg_we;
  assign wb.wb_sel = wb_st.ctrl.rd;
  assign wb.wb_data = wb_data_q;

endmodule

// ==== test/tb_commit_checker.sv ====
`include "lc4_defs.svh"

module tb_commit_checker (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  logic                   i_commit_valid,
  input  logic [`LC4_WORD_W-1:0] i_commit_pc,
  input  logic [`LC4_WORD_W-1:0] i_commit_insn,
  input  logic                   i_commit_reg_we,
  input  logic [`LC4_SEL_W-1:0]  i_commit_reg_sel,
  input  logic [`LC4_WORD_W-1:0] i_commit_reg_data,
  input  logic                   i_dmem_we,
  input  logic [`LC4_WORD_W-1:0] i_dmem_addr,
  input  logic [`LC4_WORD_W-1:0] i_dmem_wdata,
  output logic                   o_done,       // All expected commits seen
  output int                     o_value_errs,
  output int                     o_other_errs
);

  string name;
  logic [`LC4_WORD_W-1:0] e_pc [8];
  logic [`LC4_WORD_W-1:0] e_insn [8];
  logic e_we [8];
  logic [`LC4_SEL_W-1:0] e_sel [8];
  logic [`LC4_WORD_W-1:0] e_data [8];
  logic [`LC4_WORD_W-1:0] s_addr;
  logic [`LC4_WORD_W-1:0] s_data;
  int n_exp = 0;
  int n_seen = 0;
  int s_exp = 0;
  int s_seen = 0;
  logic rst_q = 1'b0;  // Reset already low at the previous edge

  initial begin
    o_value_errs = 0;
    o_other_errs = 0;
  end

  task automatic start_test(input string t_name);
    name = t_name;
    n_exp = 0;
    n_seen = 0;
    s_exp = 0;
    s_seen = 0;
  endtask

  task automatic expect_commit(input logic [15:0] pc, input logic [15:0] insn,
                               input logic we, input logic [2:0] sel,
                               input logic [15:0] data);
    e_pc[n_exp] = pc;
    e_insn[n_exp] = insn;
    e_we[n_exp] = we;
    e_sel[n_exp] = sel;
    e_data[n_exp] = data;
    n_exp++;
  endtask

  task automatic expect_store(input logic [15:0] addr, input logic [15:0] data);
    s_addr = addr;
    s_data = data;
    s_exp = 1;  // At most one store per test
  endtask

  task automatic check_word(input string what, input logic [15:0] exp,
                            input logic [15:0] act);
    if (act !== exp) begin
      $display("Error %s %s: expected %h, actual %h", name, what, exp, act);
      o_value_errs++;
    end
  endtask

  task automatic end_test();
    if (n_seen < n_exp) begin
      $display("Test %s stopped after %0d of %0d commits", name, n_seen, n_exp);
      o_other_errs++;
    end
    if (s_seen < s_exp) begin
      $display("Test %s never performed its store", name);
      o_other_errs++;
    end
  endtask

  assign o_done = (n_seen >= n_exp);

  always @(posedge gwe) begin
    if (!i_rst_n) begin
      // Pipeline is cleared by the first reset edge
      if (rst_q && (i_commit_valid === 1'b1 || i_dmem_we === 1'b1)) begin
        $display("Test %s saw a commit or store while reset was held", name);
        o_other_errs++;
      end
      rst_q <= 1'b1;
    end else begin
      rst_q <= 1'b0;
      if (i_commit_valid === 1'b1 && n_seen < n_exp) begin  // Trailing NOPs ignored
        check_word("pc", e_pc[n_seen], i_commit_pc);
        check_word("insn", e_insn[n_seen], i_commit_insn);
        check_word("reg_we", {15'b0, e_we[n_seen]}, {15'b0, i_commit_reg_we});
        if (e_we[n_seen]) begin
          check_word("reg_sel", {13'b0, e_sel[n_seen]}, {13'b0, i_commit_reg_sel});
          check_word("reg_data", e_data[n_seen], i_commit_reg_data);
        end
        n_seen++;
      end
      if (i_dmem_we === 1'b1) begin
        if (s_seen < s_exp) begin
          check_word("store addr", s_addr, i_dmem_addr);
          check_word("store data", s_data, i_dmem_wdata);
          s_seen++;
        end else begin
          $display("Test %s wrote memory at %h without a store", name, i_dmem_addr);
          o_other_errs++;
        end
      end
    end
  end

endmodule

// ==== test/tb_lc4.sv ====
`include "lc4_defs.svh"

module tb_lc4;

  localparam int NT = 6;
  localparam int TEST_CYCLES = 20;

  logic gwe = 1'b0;
  logic rst_n;
  logic [15:0] imem_addr, imem_insn, dmem_addr, dmem_wdata, dmem_rdata;
  logic dmem_we, c_valid, c_we;
  logic [15:0] c_pc, c_insn, c_data;
  logic [2:0] c_sel;
  logic done;
  int value_errs, other_errs;

  logic [15:0] prog [8];       // Program under test at 0x8200
  logic [15:0] dmem [0:65535];
  logic [31:0] lfsr = 32'h1a78;

  // Test table
  string t_name [NT];
  logic [15:0] t_prog [NT][8];
  logic [15:0] t_daddr [NT];
  logic [15:0] t_ddata [NT];
  int t_ncommit [NT];
  int t_cidx [NT][8];          // Commit PC as offset from reset PC
  logic t_cwe [NT][8];
  logic [2:0] t_csel [NT][8];
  logic [15:0] t_cdata [NT][8];
  logic t_store [NT];
  logic [15:0] t_saddr [NT];
  logic [15:0] t_sdata [NT];

  always #4 gwe = ~gwe;

  assign imem_insn = (imem_addr[15:3] == 13'h1040) ? prog[imem_addr[2:0]] : 16'h0000;
  assign dmem_rdata = dmem[dmem_addr];

  always @(posedge gwe) begin
    if (dmem_we) dmem[dmem_addr] <= dmem_wdata;
  end

  lc4_processor u_lc4_processor (
    .gwe(gwe), .i_rst_n(rst_n), .o_imem_addr(imem_addr), .i_imem_insn(imem_insn),
    .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_wdata(dmem_wdata),
    .i_dmem_rdata(dmem_rdata), .o_commit_valid(c_valid), .o_commit_pc(c_pc),
    .o_commit_insn(c_insn), .o_commit_reg_we(c_we), .o_commit_reg_sel(c_sel),
    .o_commit_reg_data(c_data)
  );

  tb_commit_checker u_checker (
    .gwe(gwe), .i_rst_n(rst_n), .i_commit_valid(c_valid), .i_commit_pc(c_pc),
    .i_commit_insn(c_insn), .i_commit_reg_we(c_we), .i_commit_reg_sel(c_sel),
    .i_commit_reg_data(c_data), .i_dmem_we(dmem_we), .i_dmem_addr(dmem_addr),
    .i_dmem_wdata(dmem_wdata), .o_done(done), .o_value_errs(value_errs),
    .o_other_errs(other_errs)
  );

  // Instruction encoders
  function automatic logic [15:0] alu_rr(input logic [3:0] op, input logic [2:0] sub,
                                         input logic [2:0] d, s, t);
    return {op, d, s, sub, t};
  endfunction
  function automatic logic [15:0] add_imm(input logic [2:0] d, s, input logic [4:0] i);
    return {4'h1, d, s, 1'b1, i};
  endfunction
  function automatic logic [15:0] const_word(input logic [2:0] d, input logic [8:0] i);
    return {4'h9, d, i};
  endfunction
  function automatic logic [15:0] mem_insn(input logic [3:0] op, input logic [2:0] r, b,
                                           input logic [5:0] off);
    return {op, r, b, off};
  endfunction
  function automatic logic [15:0] branch_insn(input logic [2:0] nzp, input logic [8:0] off);
    return {4'h0, nzp, off};
  endfunction
  function automatic logic [15:0] jump_insn(input logic [10:0] off);
    return {4'hC, 1'b1, off};
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    repeat (n) begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic add_commit(input int t, input int idx, input logic we,
                            input logic [2:0] sel, input logic [15:0] data);
    int k;
    k = t_ncommit[t];
    t_cidx[t][k] = idx;
    t_cwe[t][k] = we;
    t_csel[t][k] = sel;
    t_cdata[t][k] = data;
    t_ncommit[t] = k + 1;
  endtask

  task automatic build_table();
    logic [15:0] c1, c2, i5, r1, r2, r3, r4, r5, r6;
    for (int t = 0; t < NT; t++) begin
      t_ncommit[t] = 0;
      t_store[t] = 1'b0;
      t_daddr[t] = 16'h0000;
      t_ddata[t] = 16'h0000;
    end
    // Dependent ALU chain, random immediates
    take_bits(9, c1);
    take_bits(9, c2);
    take_bits(5, i5);
    r1 = {{7{c1[8]}}, c1[8:0]};
    r2 = {{7{c2[8]}}, c2[8:0]};
    r3 = r1 + r2;
    r4 = r3 + {{11{i5[4]}}, i5[4:0]};
    r5 = r4 - r1;
    r6 = r5 & r4;
    t_name[0] = "alu_chain";
    t_prog[0] = '{const_word(1, c1[8:0]), const_word(2, c2[8:0]), alu_rr(1, 0, 3, 1, 2),
                  add_imm(3, 3, i5[4:0]), alu_rr(1, 2, 4, 3, 1), alu_rr(5, 0, 5, 4, 3),
                  alu_rr(5, 2, 6, 5, 2), alu_rr(5, 3, 7, 6, 4)};
    add_commit(0, 0, 1, 1, r1);
    add_commit(0, 1, 1, 2, r2);
    add_commit(0, 2, 1, 3, r3);
    add_commit(0, 3, 1, 3, r4);
    add_commit(0, 4, 1, 4, r5);
    add_commit(0, 5, 1, 5, r6);
    add_commit(0, 6, 1, 6, r6 | r2);
    add_commit(0, 7, 1, 7, (r6 | r2) ^ r5);
    // Load followed by a dependent add
    t_name[1] = "load_use";
    t_prog[1] = '{const_word(1, 9'h010), const_word(2, 9'h005), mem_insn(4'h6, 3, 1, 6'd2),
                  alu_rr(1, 0, 4, 3, 2), 16'h0000, 16'h0000, 16'h0000, 16'h0000};
    t_daddr[1] = 16'h0012;
    t_ddata[1] = 16'h1234;
    add_commit(1, 0, 1, 1, 16'h0010);
    add_commit(1, 1, 1, 2, 16'h0005);
    add_commit(1, 2, 1, 3, 16'h1234);
    add_commit(1, 3, 1, 4, 16'h1239);
    // Store, then load it back
    t_name[2] = "store_load";
    t_prog[2] = '{const_word(1, 9'h020), const_word(2, 9'h1fd),
                  mem_insn(4'h7, 2, 1, 6'd4), mem_insn(4'h6, 3, 1, 6'd4),
                  alu_rr(1, 0, 4, 3, 2), 16'h0000, 16'h0000, 16'h0000};
    t_store[2] = 1'b1;
    t_saddr[2] = 16'h0024;
    t_sdata[2] = 16'hfffd;
    add_commit(2, 0, 1, 1, 16'h0020);
    add_commit(2, 1, 1, 2, 16'hfffd);
    add_commit(2, 2, 0, 0, 16'h0000);
    add_commit(2, 3, 1, 3, 16'hfffd);
    add_commit(2, 4, 1, 4, 16'hfffa);
    // Taken BRz skips two, BRzp on negative falls through
    t_name[3] = "branch";
    t_prog[3] = '{const_word(1, 9'h000), branch_insn(3'b010, 9'd2),
                  const_word(2, 9'h001), const_word(3, 9'h002), const_word(4, 9'h1ff),
                  branch_insn(3'b011, 9'd1), const_word(5, 9'h007), 16'h0000};
    add_commit(3, 0, 1, 1, 16'h0000);
    add_commit(3, 1, 0, 0, 16'h0000);
    add_commit(3, 4, 1, 4, 16'hffff);
    add_commit(3, 5, 0, 0, 16'h0000);
    add_commit(3, 6, 1, 5, 16'h0007);
    // JMP to PC+1+3
    t_name[4] = "jump";
    t_prog[4] = '{const_word(1, 9'h003), jump_insn(11'd3), const_word(2, 9'h011),
                  const_word(3, 9'h022), const_word(7, 9'h033), const_word(6, 9'h055),
                  16'h0000, 16'h0000};
    add_commit(4, 0, 1, 1, 16'h0003);
    add_commit(4, 1, 0, 0, 16'h0000);
    add_commit(4, 5, 1, 6, 16'h0055);
    // Reset behaviour on a short program
    t_name[5] = "reset";
    t_prog[5] = '{const_word(0, 9'h180), alu_rr(1, 0, 0, 0, 0), 16'h0000, 16'h0000,
                  16'h0000, 16'h0000, 16'h0000, 16'h0000};
    add_commit(5, 0, 1, 0, 16'hff80);
    add_commit(5, 1, 1, 0, 16'hff00);
  endtask

  task automatic apply_test(input int t);
    int cyc;
    @(negedge gwe);
    rst_n = 1'b0;
    for (int a = 0; a < 65536; a++) dmem[a] = {a[7:0], a[15:8]} ^ 16'h3c3c;
    dmem[t_daddr[t]] = t_ddata[t];
    for (int i = 0; i < 8; i++) prog[i] = t_prog[t][i];
    u_checker.start_test(t_name[t]);
    for (int k = 0; k < t_ncommit[t]; k++)
      u_checker.expect_commit(`LC4_RESET_PC + t_cidx[t][k], t_prog[t][t_cidx[t][k]],
                              t_cwe[t][k], t_csel[t][k], t_cdata[t][k]);
    if (t_store[t]) u_checker.expect_store(t_saddr[t], t_sdata[t]);
    repeat (2) @(negedge gwe);  // Two reset edges
    rst_n = 1'b1;
    cyc = 0;
    while (!done && cyc < 16) begin
      @(negedge gwe);
      cyc++;
    end
    u_checker.end_test();
  endtask

  initial begin
    rst_n = 1'b0;
    for (int i = 0; i < 8; i++) prog[i] = 16'h0000;
    build_table();
    for (int t = 0; t < NT; t++) apply_test(t);
    @(negedge gwe);
    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NT * TEST_CYCLES * 8);
    $display("Watchdog expired before the tests finished");
    $display("Errors found");
    $finish;
  end

endmodule
